//--- sim/aib_cfg_golden.txt
208 0000
20a 0200
210 0001
212 0000
218 0000
21a 2080
21c 0000
21e 0000
31c 0000
31e 0000
320 0000
322 0000
324 0000
326 0000
328 0000
32a 0000

//--- vlog.f
logic/aib_cfg_pkg.sv
logic/cfg_write_gen.sv
logic/cfg_write_fifo.sv
logic/apb_cfg_master.sv
logic/link_bringup_ctrl.sv
logic/aib_bringup_top.sv
sim/aib_bringup_assert.sv
sim/tb_aib_bringup.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_aib_bringup -o tb_aib_bringup \
    -f vlog.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_aib_bringup > sim.log 2>&1
cat sim.log
grep -qx "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/tb_aib_bringup.sv
`timescale 1ns/1ns
`default_nettype none

module tb_aib_bringup;

    import aib_cfg_pkg::*;

    localparam int RESET_CYCLES = 5;
    // at most 6 edges per write with 3 wait states
    localparam int WRITE_LIMIT  = TOTAL_WRITES * 8;

    localparam int SEL_CONF_DONE    = 0;
    localparam int SEL_ADAPTER_RSTN = 1;
    localparam int SEL_LOCK_REQ     = 2;
    localparam int SEL_AIB_READY    = 3;
    localparam int SEL_LINK_ERR     = 4;

    logic                    avmm_clk;
    logic                    tb_do_aib_reset;
    cfg_addr_t               paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    cfg_data_t               pwdata;
    logic                    pready = 1'b0;
    logic                    pslverr = 1'b0;
    logic [NUM_CHANNELS-1:0] ms_transfer_en;
    logic [NUM_CHANNELS-1:0] sl_transfer_en;
    logic                    conf_done;
    logic                    ns_mac_rdy;
    logic                    ns_adapter_rstn;
    logic                    dll_lock_req;
    logic                    aib_ready;
    logic                    link_err;
    logic                    cfg_err;

    logic [OFFSET_WIDTH-1:0] gold_off [REGS_PER_CHANNEL];
    cfg_data_t               gold_data [REGS_PER_CHANNEL];

    logic [31:0] lfsr_state = 32'h407d_2383;
    int          cyc = 0;
    int          writes_done = 0;
    int          last_ack_cyc = 0;
    int          wait_left = 0;
    int          wait_draw;
    int          err_index;
    logic        was_setup = 1'b0;
    logic        was_wait = 1'b0;
    cfg_addr_t   held_addr;
    cfg_data_t   held_data;

    aib_bringup_top dut0 (
        .avmm_clk          (avmm_clk),
        .tb_do_aib_reset   (tb_do_aib_reset),
        .o_paddr           (paddr),
        .o_psel            (psel),
        .o_penable         (penable),
        .o_pwrite          (pwrite),
        .o_pwdata          (pwdata),
        .i_pready          (pready),
        .i_pslverr         (pslverr),
        .i_ms_transfer_en  (ms_transfer_en),
        .i_sl_transfer_en  (sl_transfer_en),
        .o_conf_done       (conf_done),
        .o_ns_mac_rdy      (ns_mac_rdy),
        .o_ns_adapter_rstn (ns_adapter_rstn),
        .o_dll_lock_req    (dll_lock_req),
        .o_aib_ready       (aib_ready),
        .o_link_err        (link_err),
        .o_cfg_err         (cfg_err)
    );

    bind apb_cfg_master aib_bringup_assert u_apb_assert (
        .i_avmm_clk        (i_avmm_clk),
        .i_tb_do_aib_reset (i_tb_do_aib_reset),
        .i_psel            (o_psel),
        .i_penable         (o_penable),
        .i_paddr           (o_paddr),
        .i_pwdata          (o_pwdata),
        .i_pready          (i_pready)
    );

    initial begin
        avmm_clk = 1'b0;
        forever #4 avmm_clk = ~avmm_clk;
    end

    // current edge index as seen before its own update
    always @(posedge avmm_clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first failing check");
    endtask

    // galois lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        int k;
        r = 0;
        for (k = 0; k < n; k++) begin
            r = (r << 1) | int'(next_rand_bit());
        end
        return r;
    endfunction

    function automatic logic status_bit(input int sel);
        case (sel)
            SEL_CONF_DONE:    return conf_done;
            SEL_ADAPTER_RSTN: return ns_adapter_rstn;
            SEL_LOCK_REQ:     return dll_lock_req;
            SEL_AIB_READY:    return aib_ready;
            default:          return link_err;
        endcase
    endfunction

    task automatic expect_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic expect_cycle(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("ERROR %s rise edge got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          k;
        int          got;
        logic [31:0] off_word;
        logic [31:0] data_word;
        fd = $fopen("sim/aib_cfg_golden.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open the golden register file");
            stop_on_failure();
        end
        for (k = 0; k < REGS_PER_CHANNEL; k++) begin
            got = $fscanf(fd, "%h %h", off_word, data_word);
            assert (got == 2) else begin
                $display("golden register file ends before all 16 entries");
                stop_on_failure();
            end
            gold_off[k]  = off_word[OFFSET_WIDTH-1:0];
            gold_data[k] = data_word[15:0];
        end
        $fclose(fd);
    endtask

    // write n goes to channel n/16 at golden table entry n%16
    task automatic check_write(input int n);
        cfg_addr_t exp_addr;
        cfg_data_t exp_data;
        int        idx;
        idx      = n % REGS_PER_CHANNEL;
        exp_addr = {CHAN_WIDTH'(n / REGS_PER_CHANNEL), gold_off[idx]};
        exp_data = gold_data[idx];
        assert (n < TOTAL_WRITES) else begin
            $display("more configuration writes arrived than the link has registers");
            stop_on_failure();
        end
        expect_bit("o_pwrite", pwrite, 1'b1);
        assert (paddr == exp_addr) else begin
            $display("ERROR o_paddr got %h expected %h", paddr, exp_addr);
            stop_on_failure();
        end
        assert (pwdata == exp_data) else begin
            $display("ERROR o_pwdata got %h expected %h", pwdata, exp_data);
            stop_on_failure();
        end
    endtask

    // ----------------------------------------------------------------------
    // apb slave model with 0..3 random wait states per transfer
    // ----------------------------------------------------------------------
    always @(posedge avmm_clk) begin
        if (tb_do_aib_reset) begin
            pready      <= 1'b0;
            pslverr     <= 1'b0;
            writes_done <= 0;
            wait_left   <= 0;
            was_setup   <= 1'b0;
            was_wait    <= 1'b0;
        end else begin
            assert (!penable || psel) else begin
                $display("apb penable was high while psel was low");
                stop_on_failure();
            end
            if (was_setup) begin
                expect_bit("o_penable", penable, 1'b1);
            end
            if (was_wait) begin
                assert (paddr == held_addr) else begin
                    $display("ERROR o_paddr got %h expected %h", paddr, held_addr);
                    stop_on_failure();
                end
                assert (pwdata == held_data) else begin
                    $display("ERROR o_pwdata got %h expected %h", pwdata, held_data);
                    stop_on_failure();
                end
            end
            was_setup <= psel && !penable;
            was_wait  <= psel && penable && !pready;
            held_addr <= paddr;
            held_data <= pwdata;

            if (psel && penable && pready) begin
                check_write(writes_done);
                writes_done  <= writes_done + 1;
                last_ack_cyc <= cyc;
                pready       <= 1'b0;
                pslverr      <= 1'b0;
            end else if (psel && !penable) begin
                wait_draw = rand_bits(2);
                if (wait_draw == 0) begin
                    pready  <= 1'b1;
                    pslverr <= (writes_done == err_index);
                end
                wait_left <= wait_draw;
            end else if (psel && penable) begin
                if (wait_left == 1) begin
                    pready  <= 1'b1;
                    pslverr <= (writes_done == err_index);
                end
                wait_left <= wait_left - 1;
            end
        end
    end

    task automatic apply_reset();
        tb_do_aib_reset <= 1'b1;
        ms_transfer_en  <= '0;
        sl_transfer_en  <= '0;
        repeat (RESET_CYCLES) @(posedge avmm_clk);
        expect_bit("o_psel", psel, 1'b0);
        expect_bit("o_penable", penable, 1'b0);
        expect_bit("o_conf_done", conf_done, 1'b0);
        expect_bit("o_ns_mac_rdy", ns_mac_rdy, 1'b0);
        expect_bit("o_ns_adapter_rstn", ns_adapter_rstn, 1'b0);
        expect_bit("o_dll_lock_req", dll_lock_req, 1'b0);
        expect_bit("o_aib_ready", aib_ready, 1'b0);
        expect_bit("o_link_err", link_err, 1'b0);
        expect_bit("o_cfg_err", cfg_err, 1'b0);
        tb_do_aib_reset <= 1'b0;
    endtask

    task automatic wait_writes();
        int n;
        n = 0;
        while (writes_done != TOTAL_WRITES) begin
            @(posedge avmm_clk);
            expect_bit("o_conf_done", conf_done, 1'b0);
            expect_bit("o_ns_mac_rdy", ns_mac_rdy, 1'b0);
            n++;
            assert (n <= WRITE_LIMIT) else begin
                $display("timeout while waiting for the configuration writes");
                stop_on_failure();
            end
        end
    endtask

    task automatic wait_rise(input int sel, input int limit, input string name,
                             output int at_cyc);
        int n;
        n = 0;
        at_cyc = -1;
        while (at_cyc < 0) begin
            @(posedge avmm_clk);
            if (status_bit(sel)) begin
                at_cyc = cyc;
            end else begin
                n++;
                assert (n <= limit) else begin
                    $display("timeout while waiting for %s to rise", name);
                    stop_on_failure();
                end
            end
        end
    endtask

    task automatic check_wakeup(output int t_lock);
        int t_conf;
        int t_rstn;
        wait_rise(SEL_CONF_DONE, 8, "o_conf_done", t_conf);
        // count loads on the final ack edge and conf_done one edge later
        expect_cycle("o_conf_done", t_conf, last_ack_cyc + 2);
        expect_bit("o_ns_mac_rdy", ns_mac_rdy, 1'b1);
        wait_rise(SEL_ADAPTER_RSTN, WAKE_WAIT_CYCLES + 8, "o_ns_adapter_rstn", t_rstn);
        expect_cycle("o_ns_adapter_rstn", t_rstn, t_conf + WAKE_WAIT_CYCLES);
        wait_rise(SEL_LOCK_REQ, WAKE_WAIT_CYCLES + 8, "o_dll_lock_req", t_lock);
        expect_cycle("o_dll_lock_req", t_lock, t_rstn + WAKE_WAIT_CYCLES);
    endtask

    // link model where all channels come up together after a delay
    task automatic raise_links_after(input int delay, output int at_cyc);
        int i;
        for (i = 0; i <= delay; i++) begin
            @(posedge avmm_clk);
            expect_bit("o_aib_ready", aib_ready, 1'b0);
            expect_bit("o_link_err", link_err, 1'b0);
        end
        ms_transfer_en <= '1;
        sl_transfer_en <= '1;
        at_cyc = cyc;
    endtask

    task automatic hold_link_err(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge avmm_clk);
            expect_bit("o_link_err", link_err, 1'b1);
            expect_bit("o_aib_ready", aib_ready, 1'b0);
        end
    endtask

    initial begin
        int t_lock;
        int t_links;
        int t_ready;
        int t_err;
        int delay;
        tb_do_aib_reset <= 1'b1;
        ms_transfer_en  <= '0;
        sl_transfer_en  <= '0;
        err_index = -1;
        load_golden();

        // ------------------------------------------------------------------
        // normal bring-up under random wait states
        // ------------------------------------------------------------------
        apply_reset();
        wait_writes();
        check_wakeup(t_lock);
        delay = rand_bits(10);
        raise_links_after(delay, t_links);
        // enables seen one edge after driving and ready one edge after loading
        wait_rise(SEL_AIB_READY, LINK_SETTLE_CYCLES + 8, "o_aib_ready", t_ready);
        expect_cycle("o_aib_ready", t_ready, t_links + 2 + LINK_SETTLE_CYCLES);
        expect_bit("o_link_err", link_err, 1'b0);
        expect_bit("o_cfg_err", cfg_err, 1'b0);

        // links held down
        apply_reset();
        wait_writes();
        check_wakeup(t_lock);
        wait_rise(SEL_LINK_ERR, LINK_TIMEOUT_CYCLES + 8, "o_link_err", t_err);
        expect_cycle("o_link_err", t_err, t_lock + LINK_TIMEOUT_CYCLES);
        hold_link_err(32);
        expect_bit("o_cfg_err", cfg_err, 1'b0);

        // one transfer answered with pslverr
        err_index = rand_bits(9) % TOTAL_WRITES;
        apply_reset();
        wait_writes();
        expect_bit("o_cfg_err", cfg_err, 1'b1);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/aib_bringup_assert.sv
`timescale 1ns/1ns
`default_nettype none

module aib_bringup_assert (
    input  wire logic                   i_avmm_clk,
    input  wire logic                   i_tb_do_aib_reset,
    input  wire logic                   i_psel,
    input  wire logic                   i_penable,
    input  wire aib_cfg_pkg::cfg_addr_t i_paddr,
    input  wire aib_cfg_pkg::cfg_data_t i_pwdata,
    input  wire logic                   i_pready
);

    // setup lasts one cycle, then access
    setup_then_access: assert property (
        @(posedge i_avmm_clk) disable iff (i_tb_do_aib_reset)
        (i_psel && !i_penable) |=> (i_psel && i_penable)
    ) else $error("apb setup phase not followed by an access phase");

    // transfer held while the slave inserts wait states
    wait_state_stable: assert property (
        @(posedge i_avmm_clk) disable iff (i_tb_do_aib_reset)
        (i_psel && i_penable && !i_pready) |=>
            (i_psel && i_penable && $stable(i_paddr) && $stable(i_pwdata))
    ) else $error("apb address or write data changed during a wait state");

    penable_needs_psel: assert property (
        @(posedge i_avmm_clk) disable iff (i_tb_do_aib_reset)
        i_penable |-> i_psel
    ) else $error("apb penable high without psel");

endmodule

`default_nettype wire

//--- logic/aib_bringup_top.sv
`timescale 1ns/1ns
`default_nettype none

module aib_bringup_top (
    input  wire logic                                 avmm_clk,
    input  wire logic                                 tb_do_aib_reset,
    // apb master port
    output aib_cfg_pkg::cfg_addr_t                    o_paddr,
    output logic                                      o_psel,
    output logic                                      o_penable,
    output logic                                      o_pwrite,
    output aib_cfg_pkg::cfg_data_t                    o_pwdata,
    input  wire logic                                 i_pready,
    input  wire logic                                 i_pslverr,
    // link status from the channels
    input  wire logic [aib_cfg_pkg::NUM_CHANNELS-1:0] i_ms_transfer_en,
    input  wire logic [aib_cfg_pkg::NUM_CHANNELS-1:0] i_sl_transfer_en,
    // wakeup and status
    output logic                                      o_conf_done,
    output logic                                      o_ns_mac_rdy,
    output logic                                      o_ns_adapter_rstn,
    output logic                                      o_dll_lock_req,
    output logic                                      o_aib_ready,
    output logic                                      o_link_err,
    output logic                                      o_cfg_err
);

    import aib_cfg_pkg::*;

    // producer to buffer
    logic      wr_valid;
    logic      wr_ready;
    cfg_addr_t wr_addr;
    cfg_data_t wr_data;

    // buffer to apb master
    logic      rd_valid;
    logic      rd_ready;
    cfg_addr_t rd_addr;
    cfg_data_t rd_data;

    // per-transfer completion
    logic      wr_ack;
    logic      wr_err;

    cfg_write_gen u_gen (
        .i_avmm_clk        (avmm_clk),
        .i_tb_do_aib_reset (tb_do_aib_reset),
        .o_wr_valid        (wr_valid),
        .o_wr_addr         (wr_addr),
        .o_wr_data         (wr_data),
        .i_wr_ready        (wr_ready)
    );

    cfg_write_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .i_avmm_clk        (avmm_clk),
        .i_tb_do_aib_reset (tb_do_aib_reset),
        .i_wr_valid        (wr_valid),
        .i_wr_addr         (wr_addr),
        .i_wr_data         (wr_data),
        .o_wr_ready        (wr_ready),
        .o_rd_valid        (rd_valid),
        .o_rd_addr         (rd_addr),
        .o_rd_data         (rd_data),
        .i_rd_ready        (rd_ready)
    );

    apb_cfg_master u_apb (
        .i_avmm_clk        (avmm_clk),
        .i_tb_do_aib_reset (tb_do_aib_reset),
        .i_rd_valid        (rd_valid),
        .i_rd_addr         (rd_addr),
        .i_rd_data         (rd_data),
        .o_rd_ready        (rd_ready),
        .o_paddr           (o_paddr),
        .o_psel            (o_psel),
        .o_penable         (o_penable),
        .o_pwrite          (o_pwrite),
        .o_pwdata          (o_pwdata),
        .i_pready          (i_pready),
        .i_pslverr         (i_pslverr),
        .o_wr_ack          (wr_ack),
        .o_wr_err          (wr_err)
    );

    link_bringup_ctrl u_ctrl (
        .i_avmm_clk        (avmm_clk),
        .i_tb_do_aib_reset (tb_do_aib_reset),
        .i_wr_ack          (wr_ack),
        .i_wr_err          (wr_err),
        .i_ms_transfer_en  (i_ms_transfer_en),
        .i_sl_transfer_en  (i_sl_transfer_en),
        .o_conf_done       (o_conf_done),
        .o_ns_mac_rdy      (o_ns_mac_rdy),
        .o_ns_adapter_rstn (o_ns_adapter_rstn),
        .o_dll_lock_req    (o_dll_lock_req),
        .o_aib_ready       (o_aib_ready),
        .o_link_err        (o_link_err),
        .o_cfg_err         (o_cfg_err)
    );

endmodule

`default_nettype wire

//--- logic/link_bringup_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module link_bringup_ctrl (
    input  wire logic                            i_avmm_clk,
    input  wire logic                            i_tb_do_aib_reset,
    input  wire logic                            i_wr_ack,
    input  wire logic                            i_wr_err,
    input  wire logic [aib_cfg_pkg::NUM_CHANNELS-1:0] i_ms_transfer_en,
    input  wire logic [aib_cfg_pkg::NUM_CHANNELS-1:0] i_sl_transfer_en,
    output logic                                 o_conf_done,
    output logic                                 o_ns_mac_rdy,
    output logic                                 o_ns_adapter_rstn,
    output logic                                 o_dll_lock_req,
    output logic                                 o_aib_ready,
    output logic                                 o_link_err,
    output logic                                 o_cfg_err
);

    import aib_cfg_pkg::*;

    // one counter covers wakeup, settle and timeout intervals
    localparam int CYC_W = $clog2(LINK_TIMEOUT_CYCLES);

    localparam logic [CYC_W-1:0] WAKE_LAST    = CYC_W'(WAKE_WAIT_CYCLES - 1);
    localparam logic [CYC_W-1:0] SETTLE_LAST  = CYC_W'(LINK_SETTLE_CYCLES - 1);
    localparam logic [CYC_W-1:0] TIMEOUT_LAST = CYC_W'(LINK_TIMEOUT_CYCLES - 1);

    bringup_state_t   state;
    write_count_t     wr_count;
    logic [CYC_W-1:0] cyc_cnt;
    logic             links_up;

    // every channel enabled in both directions
    assign links_up = (&i_ms_transfer_en) & (&i_sl_transfer_en);

    always_ff @(posedge i_avmm_clk) begin
        if (i_tb_do_aib_reset) begin
            state             <= ST_CONFIG;
            wr_count          <= '0;
            cyc_cnt           <= '0;
            o_conf_done       <= 1'b0;
            o_ns_mac_rdy      <= 1'b0;
            o_ns_adapter_rstn <= 1'b0;
            o_dll_lock_req    <= 1'b0;
            o_aib_ready       <= 1'b0;
            o_link_err        <= 1'b0;
            o_cfg_err         <= 1'b0;
        end else begin
            // sticky, any failed write
            if (i_wr_err) begin
                o_cfg_err <= 1'b1;
            end

            case (state)
                ST_CONFIG: begin
                    if (wr_count == write_count_t'(TOTAL_WRITES)) begin
                        o_conf_done  <= 1'b1;
                        o_ns_mac_rdy <= 1'b1;
                        cyc_cnt      <= '0;
                        state        <= ST_MAC_RDY;
                    end else if (i_wr_ack) begin
                        wr_count <= wr_count + 1'b1;
                    end
                end

                // --------------------------------------------------------------
                // wakeup steps, each WAKE_WAIT_CYCLES apart
                // --------------------------------------------------------------
                ST_MAC_RDY: begin
                    if (cyc_cnt == WAKE_LAST) begin
                        o_ns_adapter_rstn <= 1'b1;
                        cyc_cnt           <= '0;
                        state             <= ST_ADAPTER_RST;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                ST_ADAPTER_RST: begin
                    if (cyc_cnt == WAKE_LAST) begin
                        o_dll_lock_req <= 1'b1;
                        cyc_cnt        <= '0;
                        state          <= ST_LOCK_REQ;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end

                // lock request just issued, then waiting, same timeout window
                ST_LOCK_REQ, ST_WAIT_LINK: begin
                    if (links_up) begin
                        cyc_cnt <= '0;
                        state   <= ST_SETTLE;
                    end else if (cyc_cnt == TIMEOUT_LAST) begin
                        o_link_err <= 1'b1;
                        state      <= ST_LINK_ERR;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                        state   <= ST_WAIT_LINK;
                    end
                end
                ST_SETTLE: begin
                    if (cyc_cnt == SETTLE_LAST) begin
                        o_aib_ready <= 1'b1;
                        state       <= ST_READY;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end

                // terminal until next reset
                ST_READY, ST_LINK_ERR: begin
                    state <= state;
                end
                default: begin
                    state <= ST_CONFIG;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/apb_cfg_master.sv
`timescale 1ns/1ns
`default_nettype none

module apb_cfg_master (
    input  wire logic                    i_avmm_clk,
    input  wire logic                    i_tb_do_aib_reset,
    input  wire logic                    i_rd_valid,
    input  wire aib_cfg_pkg::cfg_addr_t  i_rd_addr,
    input  wire aib_cfg_pkg::cfg_data_t  i_rd_data,
    output logic                         o_rd_ready,
    output aib_cfg_pkg::cfg_addr_t       o_paddr,
    output logic                         o_psel,
    output logic                         o_penable,
    output logic                         o_pwrite,
    output aib_cfg_pkg::cfg_data_t       o_pwdata,
    input  wire logic                    i_pready,
    input  wire logic                    i_pslverr,
    output logic                         o_wr_ack,
    output logic                         o_wr_err
);

    import aib_cfg_pkg::*;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_t;

    apb_state_t state;
    cfg_addr_t  addr_q;
    cfg_data_t  data_q;
    logic       pop;

    assign o_rd_ready = (state == APB_IDLE);
    assign pop        = i_rd_valid & o_rd_ready;

    assign o_psel    = (state != APB_IDLE);
    assign o_penable = (state == APB_ACCESS);
    // write-only port
    assign o_pwrite  = 1'b1;
    assign o_paddr   = addr_q;
    assign o_pwdata  = data_q;

    // completion is the access-phase edge with pready high
    assign o_wr_ack = (state == APB_ACCESS) & i_pready;
    assign o_wr_err = o_wr_ack & i_pslverr;

    // ----------------------------------------------------------------------
    // idle -> setup (one cycle) -> access (until pready)
    // ----------------------------------------------------------------------
    always_ff @(posedge i_avmm_clk) begin
        if (i_tb_do_aib_reset) begin
            state <= APB_IDLE;
        end else begin
            case (state)
                APB_IDLE: begin
                    if (pop) begin
                        state <= APB_SETUP;
                    end
                end
                APB_SETUP: begin
                    state <= APB_ACCESS;
                end
                APB_ACCESS: begin
                    if (i_pready) begin
                        state <= APB_IDLE;
                    end
                end
                default: begin
                    state <= APB_IDLE;
                end
            endcase
        end
    end

    // entry owned for the whole transfer, stable across wait states
    always_ff @(posedge i_avmm_clk) begin
        if (pop) begin
            addr_q <= i_rd_addr;
            data_q <= i_rd_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/cfg_write_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module cfg_write_fifo #(
    parameter int DEPTH = aib_cfg_pkg::FIFO_DEPTH
) (
    input  wire logic                    i_avmm_clk,
    input  wire logic                    i_tb_do_aib_reset,
    input  wire logic                    i_wr_valid,
    input  wire aib_cfg_pkg::cfg_addr_t  i_wr_addr,
    input  wire aib_cfg_pkg::cfg_data_t  i_wr_data,
    output logic                         o_wr_ready,
    output logic                         o_rd_valid,
    output aib_cfg_pkg::cfg_addr_t       o_rd_addr,
    output aib_cfg_pkg::cfg_data_t       o_rd_data,
    input  wire logic                    i_rd_ready
);

    import aib_cfg_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    cfg_addr_t mem_addr [DEPTH];
    cfg_data_t mem_data [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign o_wr_ready = (count != FULL_CNT);
    assign o_rd_valid = (count != '0);
    assign o_rd_addr  = mem_addr[rd_ptr];
    assign o_rd_data  = mem_data[rd_ptr];

    assign push = i_wr_valid & o_wr_ready;
    assign pop  = o_rd_valid & i_rd_ready;

    // storage
    always_ff @(posedge i_avmm_clk) begin
        if (push) begin
            mem_addr[wr_ptr] <= i_wr_addr;
            mem_data[wr_ptr] <= i_wr_data;
        end
    end

    // pointers and occupancy, push and pop may coincide
    always_ff @(posedge i_avmm_clk) begin
        if (i_tb_do_aib_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/cfg_write_gen.sv
`timescale 1ns/1ns
`default_nettype none

module cfg_write_gen (
    input  wire logic                  i_avmm_clk,
    input  wire logic                  i_tb_do_aib_reset,
    output logic                       o_wr_valid,
    output aib_cfg_pkg::cfg_addr_t     o_wr_addr,
    output aib_cfg_pkg::cfg_data_t     o_wr_data,
    input  wire logic                  i_wr_ready
);

    import aib_cfg_pkg::*;

    localparam int IDX_W = $clog2(REGS_PER_CHANNEL);

    localparam logic [IDX_W-1:0]      LAST_IDX  = IDX_W'(REGS_PER_CHANNEL - 1);
    localparam logic [CHAN_WIDTH-1:0] LAST_CHAN = CHAN_WIDTH'(NUM_CHANNELS - 1);

    logic [CHAN_WIDTH-1:0] chan_q;
    logic [IDX_W-1:0]      idx_q;
    logic                  done_q;
    logic                  push;

    // entry is offered as soon as reset lets go
    assign o_wr_valid = ~done_q;
    assign o_wr_addr  = {chan_q, REG_OFFSET_TABLE[idx_q]};
    assign o_wr_data  = REG_DATA_TABLE[idx_q];

    assign push = o_wr_valid & i_wr_ready;

    // ----------------------------------------------------------------------
    // walk channel 0..23, table index 0..15 inside each channel
    // ----------------------------------------------------------------------
    always_ff @(posedge i_avmm_clk) begin
        if (i_tb_do_aib_reset) begin
            chan_q <= '0;
            idx_q  <= '0;
            done_q <= 1'b0;
        end else if (push) begin
            if (idx_q == LAST_IDX) begin
                idx_q <= '0;
                if (chan_q == LAST_CHAN) begin
                    // last register of last channel accepted
                    done_q <= 1'b1;
                end else begin
                    chan_q <= chan_q + 1'b1;
                end
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/aib_cfg_pkg.sv
`default_nettype none

package aib_cfg_pkg;

    // ----------------------------------------------------------------------
    // link geometry
    // ----------------------------------------------------------------------
    localparam int NUM_CHANNELS     = 24;
    localparam int REGS_PER_CHANNEL = 16;
    localparam int TOTAL_WRITES     = NUM_CHANNELS * REGS_PER_CHANNEL;

    localparam int OFFSET_WIDTH = 11;
    localparam int CHAN_WIDTH   = 5;

    // channel number sits above the register offset
    typedef logic [CHAN_WIDTH+OFFSET_WIDTH-1:0] cfg_addr_t;
    typedef logic [15:0]                        cfg_data_t;
    typedef logic [$clog2(TOTAL_WRITES+1)-1:0]  write_count_t;

    // ----------------------------------------------------------------------
    // per-channel register image, 1x fifo mode, dbi off
    // ----------------------------------------------------------------------
    localparam logic [0:REGS_PER_CHANNEL-1][OFFSET_WIDTH-1:0] REG_OFFSET_TABLE = {
        11'h208, 11'h20a, 11'h210, 11'h212, 11'h218, 11'h21a, 11'h21c, 11'h21e,
        11'h31c, 11'h31e, 11'h320, 11'h322, 11'h324, 11'h326, 11'h328, 11'h32a
    };

    localparam cfg_data_t [0:REGS_PER_CHANNEL-1] REG_DATA_TABLE = {
        16'h0000, 16'h0200, 16'h0001, 16'h0000, 16'h0000, 16'h2080, 16'h0000, 16'h0000,
        16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000
    };

    // write buffer between table walker and apb master
    localparam int FIFO_DEPTH = 4;

    // wakeup and link-up intervals, in avmm_clk cycles
    localparam int WAKE_WAIT_CYCLES    = 250;
    localparam int LINK_SETTLE_CYCLES  = 25;
    localparam int LINK_TIMEOUT_CYCLES = 4096;

    typedef enum logic [2:0] {
        ST_CONFIG,
        ST_MAC_RDY,
        ST_ADAPTER_RST,
        ST_LOCK_REQ,
        ST_WAIT_LINK,
        ST_SETTLE,
        ST_READY,
        ST_LINK_ERR
    } bringup_state_t;

endpackage

`default_nettype wire
